// ==== hdl/core_pkg.sv ====
package core_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // base opcodes of the supported rv32i subset
  typedef enum logic [6:0] {
    op     = 7'b0110011,
    op_imm = 7'b0010011,
    lui    = 7'b0110111,
    auipc  = 7'b0010111,
    branch = 7'b1100011,
    jal    = 7'b1101111,
    jalr   = 7'b1100111,
    load   = 7'b0000011,
    store  = 7'b0100011,
    system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu,
    alu_pass_b
  } alu_op_e;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    opcode_e               opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm12;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    opcode_e               opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_hi; // also the b-type high bits
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    opcode_e               opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0]           imm20; // j-type bits are scrambled in here
    logic [reg_addr_w-1:0] rd;
    opcode_e               opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
  } inst_u;

endpackage

// ==== hdl/stage_ifs.sv ====
`timescale 1ns/1ps

interface fetch_if;
  logic                     valid;
  logic                     ready;
  logic [core_pkg::xlen-1:0] pc;
  logic [core_pkg::xlen-1:0] inst;

  modport source(output valid, pc, inst, input ready);
  modport sink(input valid, pc, inst, output ready);
endinterface

interface reg_read_if;
  logic [core_pkg::reg_addr_w-1:0] rs1;
  logic [core_pkg::reg_addr_w-1:0] rs2;
  logic [core_pkg::xlen-1:0]       rs1_data;
  logic [core_pkg::xlen-1:0]       rs2_data;

  modport reader(output rs1, rs2, input rs1_data, rs2_data);
  modport file(input rs1, rs2, output rs1_data, rs2_data);
endinterface

interface decode_if;
  logic                            valid;
  logic                            ready;
  logic [core_pkg::xlen-1:0]       pc;
  core_pkg::alu_op_e               alu_op;
  logic [core_pkg::xlen-1:0]       operand_a;
  logic [core_pkg::xlen-1:0]       operand_b;
  logic [core_pkg::xlen-1:0]       rs2_data;
  logic [core_pkg::xlen-1:0]       imm;
  logic [core_pkg::reg_addr_w-1:0] rd;
  logic                            rd_we;
  logic                            mem_re;
  logic                            mem_we;
  logic                            is_branch;
  logic [2:0]                      funct3;
  logic                            is_jal;
  logic                            is_jalr;
  logic                            halt;

  modport source(output valid, pc, alu_op, operand_a, operand_b, rs2_data, imm, rd, rd_we,
                 mem_re, mem_we, is_branch, funct3, is_jal, is_jalr, halt, input ready);
  modport sink(input valid, pc, alu_op, operand_a, operand_b, rs2_data, imm, rd, rd_we,
               mem_re, mem_we, is_branch, funct3, is_jal, is_jalr, halt, output ready);
endinterface

interface execute_if;
  logic                            valid;
  logic                            ready;
  logic [core_pkg::xlen-1:0]       pc;
  logic [core_pkg::xlen-1:0]       next_pc;
  logic [core_pkg::xlen-1:0]       result;
  logic [core_pkg::xlen-1:0]       store_data;
  logic [core_pkg::reg_addr_w-1:0] rd;
  logic                            rd_we;
  logic                            mem_re;
  logic                            mem_we;
  logic                            halt;

  modport source(output valid, pc, next_pc, result, store_data, rd, rd_we, mem_re, mem_we,
                 halt, input ready);
  modport sink(input valid, pc, next_pc, result, store_data, rd, rd_we, mem_re, mem_we,
               halt, output ready);
endinterface

// no ready here, writeback never stalls
interface memory_if;
  logic                            valid;
  logic [core_pkg::xlen-1:0]       pc;
  logic [core_pkg::xlen-1:0]       next_pc;
  logic [core_pkg::xlen-1:0]       wd;
  logic [core_pkg::reg_addr_w-1:0] rd;
  logic                            rd_we;
  logic                            halt;

  modport source(output valid, pc, next_pc, wd, rd, rd_we, halt);
  modport sink(input valid, pc, next_pc, wd, rd, rd_we, halt);
endinterface

// ==== hdl/ifu.sv ====
`timescale 1ns/1ps

module ifu #(
  parameter logic [31:0] reset_pc = 32'h8000_0000
) (
  input  logic                      clk,
  input  logic                      rst,
  output logic                      imem_req,
  output logic [core_pkg::xlen-1:0] imem_addr,
  input  logic                      imem_rvalid,
  input  logic [core_pkg::xlen-1:0] imem_rdata,
  input  logic                      commit,
  input  logic [core_pkg::xlen-1:0] commit_pc,
  input  logic                      halt,
  fetch_if.source                   fetch
);

  logic [core_pkg::xlen-1:0] pc;
  logic start; // first fetch still owed after reset

  assign imem_addr = pc;
  assign fetch.pc = pc; // pc only moves on commit, after idu took the word

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
      start <= 1'b1;
      imem_req <= 1'b0;
      fetch.valid <= 1'b0;
    end else begin
      if (fetch.valid && fetch.ready)
        fetch.valid <= 1'b0;
      if (imem_req && imem_rvalid) begin
        imem_req <= 1'b0;
        fetch.valid <= 1'b1;
      end
      if (start && !halt) begin
        imem_req <= 1'b1;
        start <= 1'b0;
      end
      if (commit && !halt) begin
        pc <= commit_pc;
        imem_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (imem_req && imem_rvalid)
      fetch.inst <= imem_rdata;
  end

  assert property (@(posedge clk) disable iff (rst) imem_req |-> imem_addr[1:0] == 2'b00);
  assert property (@(posedge clk) disable iff (rst)
    imem_req && !imem_rvalid |=> imem_req && $stable(imem_addr));

endmodule

// ==== hdl/idu.sv ====
`timescale 1ns/1ps

module idu (
  input  logic        clk,
  input  logic        rst,
  fetch_if.sink       fetch,
  reg_read_if.reader  regs,
  decode_if.source    dec
);

  core_pkg::inst_u inst_q;
  core_pkg::opcode_e opc;
  logic [core_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign fetch.ready = !dec.valid || dec.ready;

  always_ff @(posedge clk) begin
    if (rst)
      dec.valid <= 1'b0;
    else if (fetch.valid && fetch.ready)
      dec.valid <= 1'b1;
    else if (dec.ready)
      dec.valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (fetch.valid && fetch.ready) begin
      inst_q <= fetch.inst;
      dec.pc <= fetch.pc;
    end
  end

  assign opc = inst_q.r_fmt.opcode;

  assign imm_i = {{20{inst_q.i_fmt.imm12[11]}}, inst_q.i_fmt.imm12};
  assign imm_s = {{20{inst_q.s_fmt.imm_hi[6]}}, inst_q.s_fmt.imm_hi, inst_q.s_fmt.imm_lo};
  assign imm_b = {{20{inst_q.s_fmt.imm_hi[6]}}, inst_q.s_fmt.imm_lo[0],
                  inst_q.s_fmt.imm_hi[5:0], inst_q.s_fmt.imm_lo[4:1], 1'b0};
  assign imm_u = {inst_q.u_fmt.imm20, 12'b0};
  assign imm_j = {{12{inst_q.u_fmt.imm20[19]}}, inst_q.u_fmt.imm20[7:0],
                  inst_q.u_fmt.imm20[8], inst_q.u_fmt.imm20[18:9], 1'b0};

  assign regs.rs1 = inst_q.r_fmt.rs1;
  assign regs.rs2 = inst_q.r_fmt.rs2;

  assign dec.rd = inst_q.r_fmt.rd;
  assign dec.funct3 = inst_q.r_fmt.funct3;
  assign dec.rs2_data = regs.rs2_data;
  assign dec.rd_we = opc inside {core_pkg::op, core_pkg::op_imm, core_pkg::lui,
                                 core_pkg::auipc, core_pkg::jal, core_pkg::jalr, core_pkg::load};
  assign dec.mem_re = opc == core_pkg::load;
  assign dec.mem_we = opc == core_pkg::store;
  assign dec.is_branch = opc == core_pkg::branch;
  assign dec.is_jal = opc == core_pkg::jal;
  assign dec.is_jalr = opc == core_pkg::jalr;
  assign dec.halt = opc == core_pkg::system && inst_q.i_fmt.imm12 == 12'h001; // ebreak

  always_comb begin
    case (opc)
      core_pkg::store:                 dec.imm = imm_s;
      core_pkg::branch:                dec.imm = imm_b;
      core_pkg::lui, core_pkg::auipc:  dec.imm = imm_u;
      core_pkg::jal:                   dec.imm = imm_j;
      default:                         dec.imm = imm_i;
    endcase
  end

  always_comb begin
    case (opc)
      core_pkg::auipc, core_pkg::jal:  dec.operand_a = dec.pc;
      core_pkg::lui, core_pkg::system: dec.operand_a = '0;
      default:                         dec.operand_a = regs.rs1_data;
    endcase
    if (opc == core_pkg::op || opc == core_pkg::branch)
      dec.operand_b = regs.rs2_data;
    else
      dec.operand_b = dec.imm;
  end

  always_comb begin
    dec.alu_op = core_pkg::alu_add; // addresses and auipc
    if (opc == core_pkg::lui) begin
      dec.alu_op = core_pkg::alu_pass_b;
    end else if (opc == core_pkg::op || opc == core_pkg::op_imm) begin
      case (inst_q.r_fmt.funct3)
        3'b000: dec.alu_op = (opc == core_pkg::op && inst_q.r_fmt.funct7[5]) ?
                             core_pkg::alu_sub : core_pkg::alu_add;
        3'b001: dec.alu_op = core_pkg::alu_sll;
        3'b010: dec.alu_op = core_pkg::alu_slt;
        3'b011: dec.alu_op = core_pkg::alu_sltu;
        3'b100: dec.alu_op = core_pkg::alu_xor;
        3'b101: dec.alu_op = inst_q.r_fmt.funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
        3'b110: dec.alu_op = core_pkg::alu_or;
        default: dec.alu_op = core_pkg::alu_and;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    fetch.valid && fetch.ready |=> inst_q.r_fmt.opcode inside {core_pkg::op,
      core_pkg::op_imm, core_pkg::lui, core_pkg::auipc, core_pkg::branch, core_pkg::jal,
      core_pkg::jalr, core_pkg::load, core_pkg::store, core_pkg::system});

endmodule

// ==== hdl/exu.sv ====
`timescale 1ns/1ps

module exu (
  input  logic      clk,
  input  logic      rst,
  decode_if.sink    dec,
  execute_if.source exe
);

  logic [core_pkg::xlen-1:0] alu_res;
  logic [core_pkg::xlen-1:0] pc_plus4;
  logic [core_pkg::xlen-1:0] next_pc;
  logic taken;

  assign dec.ready = !exe.valid || exe.ready;
  assign pc_plus4 = dec.pc + 32'd4;

  always_comb begin
    case (dec.alu_op)
      core_pkg::alu_add:  alu_res = dec.operand_a + dec.operand_b;
      core_pkg::alu_sub:  alu_res = dec.operand_a - dec.operand_b;
      core_pkg::alu_and:  alu_res = dec.operand_a & dec.operand_b;
      core_pkg::alu_or:   alu_res = dec.operand_a | dec.operand_b;
      core_pkg::alu_xor:  alu_res = dec.operand_a ^ dec.operand_b;
      core_pkg::alu_sll:  alu_res = dec.operand_a << dec.operand_b[4:0];
      core_pkg::alu_srl:  alu_res = dec.operand_a >> dec.operand_b[4:0];
      core_pkg::alu_sra:  alu_res = $signed(dec.operand_a) >>> dec.operand_b[4:0];
      core_pkg::alu_slt:  alu_res = {31'b0, $signed(dec.operand_a) < $signed(dec.operand_b)};
      core_pkg::alu_sltu: alu_res = {31'b0, dec.operand_a < dec.operand_b};
      default:            alu_res = dec.operand_b;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      3'b000:  taken = dec.operand_a == dec.operand_b;
      3'b001:  taken = dec.operand_a != dec.operand_b;
      3'b100:  taken = $signed(dec.operand_a) < $signed(dec.operand_b);
      3'b101:  taken = $signed(dec.operand_a) >= $signed(dec.operand_b);
      3'b110:  taken = dec.operand_a < dec.operand_b;
      3'b111:  taken = dec.operand_a >= dec.operand_b;
      default: taken = 1'b0;
    endcase
    if (dec.is_jalr)
      next_pc = alu_res & ~32'd1;
    else if (dec.is_jal || (dec.is_branch && taken))
      next_pc = dec.pc + dec.imm;
    else
      next_pc = pc_plus4;
  end

  always_ff @(posedge clk) begin
    if (rst)
      exe.valid <= 1'b0;
    else if (dec.valid && dec.ready)
      exe.valid <= 1'b1;
    else if (exe.ready)
      exe.valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (dec.valid && dec.ready) begin
      exe.pc <= dec.pc;
      exe.next_pc <= next_pc;
      exe.result <= (dec.is_jal || dec.is_jalr) ? pc_plus4 : alu_res; // link value
      exe.store_data <= dec.rs2_data;
      exe.rd <= dec.rd;
      exe.rd_we <= dec.rd_we;
      exe.mem_re <= dec.mem_re;
      exe.mem_we <= dec.mem_we;
      exe.halt <= dec.halt;
    end
  end

endmodule

// ==== hdl/lsu.sv ====
`timescale 1ns/1ps

module lsu (
  input  logic                      clk,
  input  logic                      rst,
  output logic                      dmem_req,
  output logic                      dmem_we,
  output logic [core_pkg::xlen-1:0] dmem_addr,
  output logic [core_pkg::xlen-1:0] dmem_wdata,
  input  logic                      dmem_rvalid,
  input  logic [core_pkg::xlen-1:0] dmem_rdata,
  execute_if.sink                   exe,
  memory_if.source                  mem
);

  logic accept;

  assign exe.ready = !dmem_req; // busy while memory is outstanding
  assign accept = exe.valid && exe.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      dmem_req <= 1'b0;
      mem.valid <= 1'b0;
    end else begin
      mem.valid <= 1'b0; // writeback takes it at once
      if (accept && (exe.mem_re || exe.mem_we))
        dmem_req <= 1'b1;
      else if (accept)
        mem.valid <= 1'b1;
      if (dmem_req && dmem_rvalid) begin
        dmem_req <= 1'b0;
        mem.valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dmem_we <= exe.mem_we;
      dmem_addr <= exe.result;
      dmem_wdata <= exe.store_data;
      mem.pc <= exe.pc;
      mem.next_pc <= exe.next_pc;
      mem.wd <= exe.result;
      mem.rd <= exe.rd;
      mem.rd_we <= exe.rd_we;
      mem.halt <= exe.halt;
    end
    if (dmem_req && dmem_rvalid && !dmem_we)
      mem.wd <= dmem_rdata; // load data
  end

  assert property (@(posedge clk) disable iff (rst) dmem_req |-> dmem_addr[1:0] == 2'b00);

endmodule

// ==== hdl/wbu.sv ====
`timescale 1ns/1ps

module wbu (
  input  logic                            clk,
  input  logic                            rst,
  output logic                            commit,
  output logic [core_pkg::xlen-1:0]       commit_pc,
  output logic                            halt,
  output logic                            retire_valid,
  output logic [core_pkg::xlen-1:0]       retire_pc,
  output logic [core_pkg::reg_addr_w-1:0] retire_rd,
  output logic                            retire_rd_we,
  output logic [core_pkg::xlen-1:0]       retire_wd,
  memory_if.sink                          mem,
  reg_read_if.file                        regs
);

  logic [core_pkg::xlen-1:0] rf [32];
  logic halt_q;
  logic we;

  assign we = mem.valid && mem.rd_we && mem.rd != '0; // x0 stays zero

  always_ff @(posedge clk) begin
    if (we)
      rf[mem.rd] <= mem.wd;
  end

  assign regs.rs1_data = (regs.rs1 == '0) ? '0 : rf[regs.rs1];
  assign regs.rs2_data = (regs.rs2 == '0) ? '0 : rf[regs.rs2];

  always_ff @(posedge clk) begin
    if (rst)
      halt_q <= 1'b0;
    else if (mem.valid && mem.halt)
      halt_q <= 1'b1;
  end

  assign halt = halt_q || (mem.valid && mem.halt);
  assign commit = mem.valid && !mem.halt; // ebreak does not restart fetch
  assign commit_pc = mem.next_pc;

  assign retire_valid = mem.valid;
  assign retire_pc = mem.pc;
  assign retire_rd = mem.rd;
  assign retire_rd_we = we;
  assign retire_wd = mem.wd;

  assert property (@(posedge clk) disable iff (rst) halt_q |-> !commit);

endmodule

// ==== hdl/core_top.sv ====
`timescale 1ns/1ps

module core_top #(
  parameter logic [31:0] reset_pc = 32'h8000_0000
) (
  input  logic                            clk,
  input  logic                            rst,
  output logic                            imem_req,
  output logic [core_pkg::xlen-1:0]       imem_addr,
  input  logic                            imem_rvalid,
  input  logic [core_pkg::xlen-1:0]       imem_rdata,
  output logic                            dmem_req,
  output logic                            dmem_we,
  output logic [core_pkg::xlen-1:0]       dmem_addr,
  output logic [core_pkg::xlen-1:0]       dmem_wdata,
  input  logic                            dmem_rvalid,
  input  logic [core_pkg::xlen-1:0]       dmem_rdata,
  output logic                            retire_valid,
  output logic [core_pkg::xlen-1:0]       retire_pc,
  output logic [core_pkg::reg_addr_w-1:0] retire_rd,
  output logic                            retire_rd_we,
  output logic [core_pkg::xlen-1:0]       retire_wd,
  output logic                            halt
);

  logic commit;
  logic [core_pkg::xlen-1:0] commit_pc;

  fetch_if    fetch_bus();
  reg_read_if reg_bus();
  decode_if   dec_bus();
  execute_if  exe_bus();
  memory_if   mem_bus();

  ifu #(.reset_pc(reset_pc)) ifu_i (
    .clk, .rst, .imem_req, .imem_addr, .imem_rvalid, .imem_rdata,
    .commit, .commit_pc, .halt, .fetch(fetch_bus.source)
  );

  idu idu_i (
    .clk, .rst, .fetch(fetch_bus.sink), .regs(reg_bus.reader), .dec(dec_bus.source)
  );

  exu exu_i (.clk, .rst, .dec(dec_bus.sink), .exe(exe_bus.source));

  lsu lsu_i (
    .clk, .rst, .dmem_req, .dmem_we, .dmem_addr, .dmem_wdata, .dmem_rvalid, .dmem_rdata,
    .exe(exe_bus.sink), .mem(mem_bus.source)
  );

  // register file lives here, read back by idu
  wbu wbu_i (
    .clk, .rst, .commit, .commit_pc, .halt,
    .retire_valid, .retire_pc, .retire_rd, .retire_rd_we, .retire_wd,
    .mem(mem_bus.sink), .regs(reg_bus.file)
  );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter time period = 40ns,
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 rst = 1'b0; // released just after an edge
  end

endmodule

// ==== verification/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

  localparam logic [31:0] reset_pc = 32'h8000_0000;
  localparam logic [31:0] seed = 32'h6fd9ee5c;

  logic clk, rst;
  logic imem_req, dmem_req, dmem_we, halt;
  logic [31:0] imem_addr, dmem_addr, dmem_wdata, retire_pc, retire_wd;
  logic imem_rvalid = 1'b0;
  logic dmem_rvalid = 1'b0;
  logic [31:0] imem_rdata = '0;
  logic [31:0] dmem_rdata = '0;
  logic retire_valid, retire_rd_we;
  logic [4:0] retire_rd;

  logic [31:0] prog [64];
  logic [31:0] dmem [logic [31:0]];
  logic [31:0] mem_exp [logic [31:0]];
  logic [31:0] shadow [32];
  int n_prog = 0;
  int errors = 0;
  int i_wait = 0;
  int d_wait = 0;
  logic seen_req = 1'b0;
  logic rst_applied = 1'b0;
  logic [31:0] cur_pc = '0;
  logic [31:0] next_q = reset_pc;

  tb_clock clock_i (.clk, .rst);

  core_top #(.reset_pc(reset_pc)) dut_i (.*);

  function automatic logic [31:0] prog_word(logic [31:0] pc);
    logic [31:0] idx;
    idx = (pc - reset_pc) >> 2;
    return (idx < 64) ? prog[idx] : 32'h0;
  endfunction

  // unwritten data words hold a pattern of their own address
  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h3c5a_9e71;
  endfunction

  function automatic logic [31:0] dmem_word(logic [31:0] addr);
    return dmem.exists(addr) ? dmem[addr] : fill_word(addr);
  endfunction

  // memory as the retired stores left it
  function automatic logic [31:0] stored_word(logic [31:0] addr);
    return mem_exp.exists(addr) ? mem_exp[addr] : fill_word(addr);
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    core_pkg::inst_u w;
    w.r_fmt.funct7 = f7;
    w.r_fmt.rs2 = rs2;
    w.r_fmt.rs1 = rs1;
    w.r_fmt.funct3 = f3;
    w.r_fmt.rd = rd;
    w.r_fmt.opcode = core_pkg::op;
    return w;
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, core_pkg::opcode_e opc);
    core_pkg::inst_u w;
    w.i_fmt.imm12 = imm;
    w.i_fmt.rs1 = rs1;
    w.i_fmt.funct3 = f3;
    w.i_fmt.rd = rd;
    w.i_fmt.opcode = opc;
    return w;
  endfunction

  // store and branch share the split layout
  function automatic logic [31:0] enc_s(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [12:0] off, logic is_br);
    core_pkg::inst_u w;
    w.s_fmt.rs2 = rs2;
    w.s_fmt.rs1 = rs1;
    w.s_fmt.funct3 = f3;
    if (is_br) begin
      w.s_fmt.imm_hi = {off[12], off[10:5]};
      w.s_fmt.imm_lo = {off[4:1], off[11]};
      w.s_fmt.opcode = core_pkg::branch;
    end else begin
      w.s_fmt.imm_hi = off[11:5];
      w.s_fmt.imm_lo = off[4:0];
      w.s_fmt.opcode = core_pkg::store;
    end
    return w;
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd,
                                        core_pkg::opcode_e opc);
    core_pkg::inst_u w;
    w.u_fmt.imm20 = imm;
    w.u_fmt.rd = rd;
    w.u_fmt.opcode = opc;
    return w;
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
    return enc_u({off[20], off[10:1], off[11], off[19:12]}, rd, core_pkg::jal);
  endfunction

  task automatic emit(logic [31:0] w);
    prog[n_prog] = w;
    n_prog++;
  endtask

  task automatic build_program();
    logic [2:0] f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [4:0] t1 [6] = '{5'd3, 5'd3, 5'd0, 5'd3, 5'd0, 5'd3}; // taken operands
    logic [4:0] t2 [6] = '{5'd3, 5'd0, 5'd3, 5'd0, 5'd3, 5'd0};
    logic [4:0] n1 [6] = '{5'd3, 5'd3, 5'd3, 5'd0, 5'd3, 5'd0}; // not taken
    logic [4:0] n2 [6] = '{5'd0, 5'd3, 5'd0, 5'd3, 5'd0, 5'd3};
    for (int k = 0; k < 64; k++)
      prog[k] = '0;
    emit(enc_u(20'($urandom), 5'd1, core_pkg::lui));
    emit(enc_i(12'($urandom), 5'd1, 3'd0, 5'd1, core_pkg::op_imm));
    emit(enc_u(20'($urandom), 5'd2, core_pkg::lui));
    emit(enc_i(12'($urandom), 5'd2, 3'd0, 5'd2, core_pkg::op_imm));
    emit(enc_i(12'd5, 5'd0, 3'd0, 5'd3, core_pkg::op_imm));
    emit(enc_i(12'd0, 5'd1, 3'd0, 5'd0, core_pkg::op_imm)); // write to x0 is dropped
    for (int k = 0; k < 8; k++)
      emit(enc_r(7'h00, 5'd2, 5'd1, k[2:0], 5'd4 + k[4:0]));
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd12)); // sub
    emit(enc_r(7'h20, 5'd3, 5'd1, 3'd5, 5'd13)); // sra
    emit(enc_i(12'($urandom), 5'd1, 3'd4, 5'd14, core_pkg::op_imm));
    emit(enc_i(12'hfff, 5'd2, 3'd2, 5'd15, core_pkg::op_imm));
    emit(enc_i({7'h20, 5'd7}, 5'd2, 3'd5, 5'd16, core_pkg::op_imm));
    emit(enc_i({7'h00, 5'd9}, 5'd1, 3'd1, 5'd17, core_pkg::op_imm));
    emit(enc_u(20'h00001, 5'd18, core_pkg::auipc));
    emit(enc_u(20'h10000, 5'd20, core_pkg::lui));
    emit(enc_s(3'd2, 5'd20, 5'd4, 13'd8, 1'b0));
    emit(enc_i(12'd8, 5'd20, 3'd2, 5'd21, core_pkg::load));
    emit(enc_i(12'd12, 5'd20, 3'd2, 5'd22, core_pkg::load));
    for (int k = 0; k < 6; k++) begin
      emit(enc_s(f3[k], t1[k], t2[k], 13'd8, 1'b1));
      emit(enc_i(12'd1, 5'd0, 3'd0, 5'd24, core_pkg::op_imm));
      emit(enc_s(f3[k], n1[k], n2[k], 13'd8, 1'b1));
      emit(enc_i(12'd2, 5'd0, 3'd0, 5'd24, core_pkg::op_imm));
    end
    emit(enc_j(21'd8, 5'd25));
    emit(enc_i(12'd3, 5'd0, 3'd0, 5'd24, core_pkg::op_imm));
    emit(enc_u(20'h0, 5'd26, core_pkg::auipc));
    emit(enc_i(12'd13, 5'd26, 3'd0, 5'd27, core_pkg::jalr)); // odd target, bit 0 drops
    emit(enc_i(12'd4, 5'd0, 3'd0, 5'd24, core_pkg::op_imm));
    emit(enc_i(12'd1, 5'd0, 3'd0, 5'd0, core_pkg::system)); // ebreak
  endtask

  // reference results straight from the rv32i rules
  function automatic logic [31:0] expect_wd(logic [31:0] w, logic [31:0] pc,
                                            logic [31:0] a, logic [31:0] b);
    logic [31:0] imm, rhs;
    imm = {{20{w[31]}}, w[31:20]};
    rhs = (w[6:0] == core_pkg::op) ? b : imm;
    case (w[6:0])
      core_pkg::lui: return {w[31:12], 12'b0};
      core_pkg::auipc: return pc + {w[31:12], 12'b0};
      core_pkg::jal, core_pkg::jalr: return pc + 32'd4;
      core_pkg::load: return stored_word(a + imm);
      default: begin
        case (w[14:12])
          3'd0: return (w[6:0] == core_pkg::op && w[30]) ? a - rhs : a + rhs;
          3'd1: return a << rhs[4:0];
          3'd2: return {31'b0, $signed(a) < $signed(rhs)};
          3'd3: return {31'b0, a < rhs};
          3'd4: return a ^ rhs;
          3'd5: return w[30] ? 32'($signed(a) >>> rhs[4:0]) : a >> rhs[4:0];
          3'd6: return a | rhs;
          default: return a & rhs;
        endcase
      end
    endcase
  endfunction

  function automatic logic [31:0] expect_next(logic [31:0] w, logic [31:0] pc,
                                              logic [31:0] a, logic [31:0] b);
    logic taken;
    case (w[14:12])
      3'd0: taken = a == b;
      3'd1: taken = a != b;
      3'd4: taken = $signed(a) < $signed(b);
      3'd5: taken = $signed(a) >= $signed(b);
      3'd6: taken = a < b;
      default: taken = a >= b;
    endcase
    if (w[6:0] == core_pkg::jal)
      return pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    if (w[6:0] == core_pkg::jalr)
      return (a + {{20{w[31]}}, w[31:20]}) & ~32'd1;
    if (w[6:0] == core_pkg::branch && taken)
      return pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    return pc + 32'd4;
  endfunction

  task automatic mismatch(string name, logic [31:0] exp, logic [31:0] act);
    errors++;
    $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
  endtask

  task automatic failure(string what);
    errors++;
    $display("%0t %s", $time, what);
  endtask

  logic [31:0] ret_w, ret_a, ret_b, exp_wd, exp_next, cur_w, exp_st_addr, exp_st_data;
  logic ret_alu, ret_jump, ret_load, ret_ebreak;
  logic ret_store, ret_wr;

  assign ret_w = prog_word(retire_pc);
  assign ret_a = shadow[ret_w[19:15]];
  assign ret_b = shadow[ret_w[24:20]];
  assign exp_wd = expect_wd(ret_w, retire_pc, ret_a, ret_b);
  assign exp_next = expect_next(ret_w, retire_pc, ret_a, ret_b);
  assign ret_alu = ret_w[6:0] inside {core_pkg::op, core_pkg::op_imm, core_pkg::lui,
                                      core_pkg::auipc};
  assign ret_jump = ret_w[6:0] inside {core_pkg::jal, core_pkg::jalr};
  assign ret_load = ret_w[6:0] == core_pkg::load;
  assign ret_store = ret_w[6:0] == core_pkg::store;
  assign ret_wr = (ret_alu || ret_jump || ret_load) && ret_w[11:7] != 5'd0;
  assign ret_ebreak = ret_w == 32'h0010_0073;
  assign cur_w = prog_word(cur_pc);
  assign exp_st_addr = shadow[cur_w[19:15]] + {{20{cur_w[31]}}, cur_w[31:25], cur_w[11:7]};
  assign exp_st_data = shadow[cur_w[24:20]];

  always @(posedge clk) begin
    if (rst)
      rst_applied <= 1'b1;
    if (imem_req && !rst)
      seen_req <= 1'b1;
    if (imem_req && imem_rvalid)
      cur_pc <= imem_addr;
    if (retire_valid) begin
      next_q <= exp_next;
      if (retire_rd_we)
        shadow[retire_rd] <= retire_wd;
      if (ret_store)
        mem_exp[ret_a + {{20{ret_w[31]}}, ret_w[31:25], ret_w[11:7]}] = ret_b;
    end
  end

  // instruction memory, 1 to 4 cycles per request
  always @(posedge clk) begin
    #1;
    if (rst || imem_rvalid) begin
      imem_rvalid = 1'b0;
    end else if (imem_req) begin
      if (i_wait == 0)
        i_wait = $urandom_range(4, 1);
      i_wait--;
      if (i_wait == 0) begin
        imem_rvalid = 1'b1;
        imem_rdata = prog_word(imem_addr);
      end
    end
  end

  always @(posedge clk) begin
    #1;
    if (rst || dmem_rvalid) begin
      dmem_rvalid = 1'b0;
    end else if (dmem_req) begin
      if (d_wait == 0)
        d_wait = $urandom_range(4, 1);
      d_wait--;
      if (d_wait == 0) begin
        dmem_rvalid = 1'b1;
        if (dmem_we)
          dmem[dmem_addr] = dmem_wdata;
        else
          dmem_rdata = dmem_word(dmem_addr);
      end
    end
  end

  assert property (@(posedge clk) rst_applied && rst |-> !imem_req)
    else failure("imem_req is high during reset");
  assert property (@(posedge clk) rst_applied && (rst || !seen_req) |->
    !dmem_req && !retire_valid && !halt)
    else failure("dmem_req, retire_valid or halt is high before the first fetch");
  assert property (@(posedge clk) disable iff (rst) imem_req && !seen_req |->
    imem_addr == reset_pc) else mismatch("imem_addr", reset_pc, $sampled(imem_addr));
  assert property (@(posedge clk) disable iff (rst) retire_valid |->
    retire_pc == next_q) else mismatch("retire_pc", $sampled(next_q), $sampled(retire_pc));
  assert property (@(posedge clk) disable iff (rst) retire_valid && ret_alu |->
    retire_wd == exp_wd) else mismatch("retire_wd", $sampled(exp_wd), $sampled(retire_wd));
  assert property (@(posedge clk) disable iff (rst) retire_valid && retire_rd == 0 |->
    !retire_rd_we) else failure("retire_rd_we is high for register 0");
  assert property (@(posedge clk) disable iff (rst) retire_valid |->
    retire_rd_we == ret_wr)
    else mismatch("retire_rd_we", $sampled(ret_wr), $sampled(retire_rd_we));
  assert property (@(posedge clk) disable iff (rst) retire_valid && ret_wr |->
    retire_rd == ret_w[11:7])
    else mismatch("retire_rd", $sampled(ret_w[11:7]), $sampled(retire_rd));
  assert property (@(posedge clk) disable iff (rst) retire_valid && !ret_ebreak |=>
    imem_req && imem_addr == next_q) else mismatch("imem_addr", next_q, $sampled(imem_addr));
  assert property (@(posedge clk) disable iff (rst) retire_valid && ret_jump |->
    retire_wd == exp_wd) else mismatch("retire_wd", $sampled(exp_wd), $sampled(retire_wd));
  assert property (@(posedge clk) disable iff (rst) dmem_req |->
    dmem_we == (cur_w[6:0] == core_pkg::store))
    else mismatch("dmem_we", $sampled(cur_w[6:0] == core_pkg::store), $sampled(dmem_we));
  assert property (@(posedge clk) disable iff (rst) dmem_req && dmem_we |->
    dmem_addr == exp_st_addr)
    else mismatch("dmem_addr", $sampled(exp_st_addr), $sampled(dmem_addr));
  assert property (@(posedge clk) disable iff (rst) dmem_req && dmem_we |->
    dmem_wdata == exp_st_data)
    else mismatch("dmem_wdata", $sampled(exp_st_data), $sampled(dmem_wdata));
  assert property (@(posedge clk) disable iff (rst) retire_valid && ret_load |->
    retire_wd == exp_wd) else mismatch("retire_wd", $sampled(exp_wd), $sampled(retire_wd));
  assert property (@(posedge clk) disable iff (rst) retire_valid && ret_ebreak |-> halt)
    else failure("halt did not rise on ebreak");
  assert property (@(posedge clk) disable iff (rst) halt |=> halt && !imem_req)
    else failure("halt fell or imem_req rose after halt");

  initial begin
    int limit;
    int cycles;
    logic timed_out;
    void'($urandom(seed));
    for (int k = 0; k < 32; k++)
      shadow[k] = '0;
    build_program();
    limit = n_prog * 14 + 20;
    cycles = 0;
    timed_out = 1'b0;
    @(negedge rst);
    while (!halt && cycles < limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!halt) begin
      timed_out = 1'b1;
      failure("core did not halt before the cycle limit");
    end else begin
      repeat (5) @(posedge clk);
    end
    $display("errors: %0d, timeout: %0d, cycles: %0d", errors, timed_out, cycles);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// ==== build.f ====
hdl/core_pkg.sv
hdl/stage_ifs.sv
hdl/ifu.sv
hdl/idu.sv
hdl/exu.sv
hdl/lsu.sv
hdl/wbu.sv
hdl/core_top.sv
verification/tb_clock.sv
verification/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - hdl/core_pkg.sv
  - hdl/stage_ifs.sv
  - hdl/ifu.sv
  - hdl/idu.sv
  - hdl/exu.sv
  - hdl/lsu.sv
  - hdl/wbu.sv
  - hdl/core_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/core_tb.sv
